// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath sizes.
`define CPU_WORD_W 32
`define CPU_NREGS  16

// Instruction fields.
`define CPU_OP_HI  31
`define CPU_OP_LO  27
`define CPU_RA_HI  26
`define CPU_RA_LO  23
`define CPU_RB_HI  22
`define CPU_RB_LO  19
`define CPU_RC_HI  18
`define CPU_RC_LO  15
`define CPU_IMM_HI 18
`define CPU_IMM_LO 0

// Opcodes.
`define OP_LDI  5'd0
`define OP_ADD  5'd3
`define OP_SUB  5'd4
`define OP_AND  5'd5
`define OP_OR   5'd6
`define OP_SHR  5'd7
`define OP_SHRA 5'd8
`define OP_SHL  5'd9
`define OP_ROR  5'd10
`define OP_ROL  5'd11
`define OP_NEG  5'd16
`define OP_NOT  5'd17

`endif

// File: common/cpuPkg.sv
`include "cpu_defs.svh"

package cpuPkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;             // Data and instruction word.
    typedef logic [$clog2(`CPU_NREGS)-1:0] regIdx_t;    // General register index.
    typedef logic [`CPU_OP_HI-`CPU_OP_LO:0] opcode_t;   // Instruction opcode field.

    // ALU operations share their codes with the opcodes.
    typedef enum logic [4:0] {
        ALU_LDI   = `OP_LDI,
        ALU_ADD   = `OP_ADD,
        ALU_SUB   = `OP_SUB,
        ALU_AND   = `OP_AND,
        ALU_OR    = `OP_OR,
        ALU_SHR   = `OP_SHR,
        ALU_SHRA  = `OP_SHRA,
        ALU_SHL   = `OP_SHL,
        ALU_ROR   = `OP_ROR,
        ALU_ROL   = `OP_ROL,
        ALU_NEG   = `OP_NEG,
        ALU_NOT   = `OP_NOT,
        ALU_INCR  = 5'd30,  // Bus operand plus one, for the PC.
        ALU_PASSB = 5'd31
    } aluOp_t;

    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_PC,
        BUS_MDR,
        BUS_ZLO,
        BUS_REG,
        BUS_IMM
    } busSrc_t;

    typedef struct packed {
        busSrc_t busSrc;
        regIdx_t regSel;
        logic    regWrite;
        logic    pcLoad;
        logic    marLoad;
        logic    mdrLoad;
        logic    irLoad;
        logic    yLoad;
        logic    zLoad;
        aluOp_t  aluOp;
    } ctrlWord_t;

    typedef struct packed {
        logic    valid;
        regIdx_t regAddr;   // Written register.
        word_t   data;
    } retire_t;

endpackage

// File: logic/registerFile.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module registerFile (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::regIdx_t regSel,
    input  logic            regWrite,
    input  cpuPkg::word_t   wrData,
    output cpuPkg::word_t   rdData
);
    import cpuPkg::*;

    word_t regs [`CPU_NREGS];

    // Combinational read onto the bus side.
    assign rdData = regs[regSel];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[regSel] <= wrData;  // Write takes the bus value.
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module alu (
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::aluOp_t op,
    output cpuPkg::word_t  result
);
    import cpuPkg::*;

    localparam int shiftW = $clog2(`CPU_WORD_W);

    logic [shiftW-1:0]         amount;
    logic [2*`CPU_WORD_W-1:0]  rotRight;
    logic [2*`CPU_WORD_W-1:0]  rotLeft;
    word_t                     shiftArith;

    assign amount = b[shiftW-1:0];  // Shift count from the low bits of B.

    // Rotates come from shifting a doubled copy of A.
    assign rotRight   = {a, a} >> amount;
    assign rotLeft    = {a, a} << amount;
    assign shiftArith = $signed(a) >>> amount;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_SHR:  result = a >> amount;
            ALU_SHRA: result = shiftArith;    // Sign fill.
            ALU_SHL:  result = a << amount;
            ALU_ROR:  result = rotRight[`CPU_WORD_W-1:0];
            ALU_ROL:  result = rotLeft[2*`CPU_WORD_W-1:`CPU_WORD_W];
            ALU_NEG:  result = -a;
            ALU_NOT:  result = ~a;
            ALU_INCR: result = b + 1'b1;      // PC on the bus plus one.
            default:  result = b;             // PASSB and anything unused.
        endcase
    end

    always_comb begin
        if (op == ALU_SHRA) begin
            assert (result[`CPU_WORD_W-1] == a[`CPU_WORD_W-1])
                else $error("shra changed the sign bit.");
        end
    end

endmodule

// File: control/controlUnit.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module controlUnit (
    input  logic              clk,
    input  logic              rst,
    input  cpuPkg::word_t     ir,
    input  logic              memReqReady,
    input  logic              memRspValid,
    output logic              memReqValid,
    output cpuPkg::ctrlWord_t ctrl,
    output logic              retireValid
);
    import cpuPkg::*;

    typedef enum logic [2:0] {T0, T1, T2, T3, T4, T5, T6} step_t;

    step_t   step;
    step_t   stepNext;
    opcode_t opcode;
    regIdx_t ra;
    regIdx_t rb;
    regIdx_t rc;
    logic    isLdi;
    logic    isAlu;

    assign opcode = ir[`CPU_OP_HI:`CPU_OP_LO];
    assign ra     = ir[`CPU_RA_HI:`CPU_RA_LO];
    assign rb     = ir[`CPU_RB_HI:`CPU_RB_LO];
    assign rc     = ir[`CPU_RC_HI:`CPU_RC_LO];

    // Instruction class.
    always_comb begin
        isLdi = (opcode == `OP_LDI);
        case (opcode)
            `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHR, `OP_SHRA,
            `OP_SHL, `OP_ROR, `OP_ROL, `OP_NEG, `OP_NOT: isAlu = 1'b1;
            default: isAlu = 1'b0;
        endcase
    end

    always_comb begin
        stepNext = step;
        case (step)
            T0: stepNext = T1;
            T1: if (memReqReady) stepNext = T2;  // Wait for the request to be taken.
            T2: if (memRspValid) stepNext = T3;  // Wait for the instruction word.
            T3: stepNext = (isLdi || isAlu) ? T4 : T0;  // Unknown opcodes are skipped.
            T4: stepNext = isLdi ? T0 : T5;
            T5: stepNext = T6;
            T6: stepNext = T0;
            default: stepNext = T0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= T0;
        end else begin
            step <= stepNext;
        end
    end

    // Control word for the current step.
    always_comb begin
        ctrl        = '0;
        ctrl.busSrc = BUS_NONE;
        ctrl.aluOp  = ALU_PASSB;
        memReqValid = 1'b0;
        retireValid = 1'b0;
        case (step)
            T0: begin
                ctrl.busSrc  = BUS_PC;
                ctrl.marLoad = 1'b1;
                ctrl.zLoad   = 1'b1;
                ctrl.aluOp   = ALU_INCR;
            end
            T1: begin
                ctrl.busSrc  = BUS_ZLO;
                ctrl.pcLoad  = 1'b1;  // Z holds PC+1 for the whole wait.
                memReqValid  = 1'b1;
            end
            T2: ctrl.mdrLoad = memRspValid;
            T3: begin
                ctrl.busSrc  = BUS_MDR;
                ctrl.irLoad  = 1'b1;
            end
            T4: begin
                if (isLdi) begin
                    ctrl.busSrc   = BUS_IMM;
                    ctrl.regSel   = ra;
                    ctrl.regWrite = 1'b1;
                    retireValid   = 1'b1;
                end else begin
                    ctrl.busSrc   = BUS_REG;  // Rb into Y.
                    ctrl.regSel   = rb;
                    ctrl.yLoad    = 1'b1;
                end
            end
            T5: begin
                ctrl.busSrc  = BUS_REG;
                ctrl.regSel  = rc;
                ctrl.zLoad   = 1'b1;
                ctrl.aluOp   = aluOp_t'(opcode);
            end
            T6: begin
                ctrl.busSrc   = BUS_ZLO;
                ctrl.regSel   = ra;
                ctrl.regWrite = 1'b1;
                retireValid   = 1'b1;
            end
            default: ;
        endcase
    end

    // A pending fetch request must not be withdrawn.
    assert property (@(posedge clk) disable iff (rst)
        memReqValid && !memReqReady |=> memReqValid)
        else $error("memReqValid dropped before memReqReady.");

endmodule

// File: datapath/datapathCore.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module datapathCore (
    input  logic              clk,
    input  logic              rst,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::word_t     regData,
    input  cpuPkg::word_t     aluResult,
    input  cpuPkg::word_t     memRspData,
    output cpuPkg::word_t     bus,
    output cpuPkg::word_t     y,
    output cpuPkg::word_t     ir,
    output cpuPkg::word_t     memReqAddr
);
    import cpuPkg::*;

    localparam int immW = `CPU_IMM_HI - `CPU_IMM_LO + 1;

    word_t pc;
    word_t mar;
    word_t mdr;
    word_t irReg;
    word_t z;
    word_t imm;
    logic  irStale;  // MDR holds a word not yet copied to IR.

    // Sign-extended constant field.
    assign imm = {{(`CPU_WORD_W - immW){irReg[`CPU_IMM_HI]}},
                  irReg[`CPU_IMM_HI:`CPU_IMM_LO]};

    always_comb begin
        case (ctrl.busSrc)
            BUS_PC:  bus = pc;
            BUS_MDR: bus = mdr;
            BUS_ZLO: bus = z;
            BUS_REG: bus = regData;
            BUS_IMM: bus = imm;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc  <= '0;
            mar <= '0;
        end else begin
            if (ctrl.pcLoad) begin
                pc <= bus;
            end
            if (ctrl.marLoad) begin
                mar <= bus;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irStale <= 1'b0;
        end else if (ctrl.mdrLoad) begin
            irStale <= 1'b1;
        end else if (ctrl.irLoad) begin
            irStale <= 1'b0;
        end
    end

    // MDR is filled straight from the fetch response.
    always_ff @(posedge clk) begin
        if (ctrl.mdrLoad) begin
            mdr <= memRspData;
        end
        if (ctrl.irLoad) begin
            irReg <= bus;
        end
        if (ctrl.yLoad) begin
            y <= bus;
        end
        if (ctrl.zLoad) begin
            z <= aluResult;
        end
    end

    // Decode sees the new word during the MDR to IR step.
    assign ir = irStale ? mdr : irReg;

    assign memReqAddr = mar;

    assert property (@(posedge clk) disable iff (rst)
        (mdr != $past(mdr)) |-> ($past(ctrl.mdrLoad) && (mdr == $past(memRspData))))
        else $error("MDR changed without a memory response load.");

endmodule

// File: logic/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
    input  logic            clk,
    input  logic            rst,
    output logic            memReqValid,
    input  logic            memReqReady,
    output cpuPkg::word_t   memReqAddr,
    input  logic            memRspValid,
    input  cpuPkg::word_t   memRspData,
    output cpuPkg::retire_t retire
);
    import cpuPkg::*;

    ctrlWord_t ctrl;
    word_t     ir;
    word_t     bus;
    word_t     y;
    word_t     regData;
    word_t     aluResult;
    logic      retireValid;

    controlUnit uControl (
        .clk         (clk),
        .rst         (rst),
        .ir          (ir),
        .memReqReady (memReqReady),
        .memRspValid (memRspValid),
        .memReqValid (memReqValid),
        .ctrl        (ctrl),
        .retireValid (retireValid)
    );

    datapathCore uDatapath (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .regData    (regData),
        .aluResult  (aluResult),
        .memRspData (memRspData),
        .bus        (bus),
        .y          (y),
        .ir         (ir),
        .memReqAddr (memReqAddr)
    );

    registerFile uRegs (
        .clk      (clk),
        .rst      (rst),
        .regSel   (ctrl.regSel),
        .regWrite (ctrl.regWrite),
        .wrData   (bus),
        .rdData   (regData)
    );

    alu uAlu (
        .a      (y),
        .b      (bus),
        .op     (ctrl.aluOp),
        .result (aluResult)
    );

    // The bus carries the value being written whenever a retire is flagged.
    assign retire = '{valid: retireValid, regAddr: ctrl.regSel, data: bus};

endmodule

// File: tb/cpuTb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int    progLen    = 40;
    localparam int    shraAddr   = 18;
    localparam word_t shraExpect = 32'hFFE0003E;
    localparam int    waitLimit  = 4000;

    logic    clk;
    logic    rst;
    logic    memReqValid;
    logic    memReqReady;
    word_t   memReqAddr;
    logic    memRspValid;
    word_t   memRspData;
    retire_t retire;

    word_t   imem [progLen];
    word_t   refRegs [`CPU_NREGS];
    regIdx_t expReg [$];   // Expected retires, oldest first.
    word_t   expData [$];
    int      expDue [$];
    int      expAddr [$];

    integer  seed = 52;
    int      cycle = 0;
    int      fetchAddr = 0;
    int      rspCount = 0;
    int      rspCountdown = 0;
    bit      rspPending = 1'b0;
    word_t   rspWord;
    int      rspAddr;
    bit      holding = 1'b0;
    word_t   heldAddr;
    int      valueErrors = 0;
    int      protocolErrors = 0;
    int      timeoutErrors = 0;
    int      waitCount;

    cpuTop DUT (
        .clk         (clk),
        .rst         (rst),
        .memReqValid (memReqValid),
        .memReqReady (memReqReady),
        .memReqAddr  (memReqAddr),
        .memRspValid (memRspValid),
        .memRspData  (memRspData),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t ldiInstr(input regIdx_t ra, input logic [18:0] imm);
        return {`OP_LDI, ra, 4'd0, imm};
    endfunction

    function automatic word_t aluInstr(input opcode_t op, input regIdx_t ra,
                                       input regIdx_t rb, input regIdx_t rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic regIdx_t randReg();
        return regIdx_t'($random(seed));
    endfunction

    // Words past the program decode as opcode 31 and are skipped.
    function automatic word_t fetchFill(input word_t addr);
        return {5'h1F, addr[26:0] ^ {22'd0, addr[31:27]}};
    endfunction

    function automatic bit isAluOpcode(input opcode_t op);
        case (op)
            `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHR, `OP_SHRA,
            `OP_SHL, `OP_ROR, `OP_ROL, `OP_NEG, `OP_NOT: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Result of Ra = Rb op Rc, with the count taken from Rc bits 4:0.
    function automatic word_t computeExpected(input opcode_t op, input word_t a, input word_t b);
        int    n;
        word_t res;
        n = int'(b[4:0]);
        case (op)
            `OP_ADD:  res = a + b;
            `OP_SUB:  res = a - b;
            `OP_AND:  res = a & b;
            `OP_OR:   res = a | b;
            `OP_SHR:  res = a >> n;
            `OP_SHRA: res = word_t'($signed(a) >>> n);
            `OP_SHL:  res = a << n;
            `OP_ROR:  res = (a >> n) | (a << (`CPU_WORD_W - n));  // Zero count leaves a.
            `OP_ROL:  res = (a << n) | (a >> (`CPU_WORD_W - n));
            `OP_NEG:  res = 32'd0 - a;
            `OP_NOT:  res = ~a;
            default:  res = '0;
        endcase
        return res;
    endfunction

    task automatic buildProgram();
        opcode_t mix [14];
        opcode_t aluOps [11];
        mix = '{`OP_LDI, `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHR, `OP_SHRA,
                `OP_SHL, `OP_ROR, `OP_ROL, `OP_NEG, `OP_NOT, 5'd2, 5'd21};
        aluOps = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHR, `OP_SHRA,
                   `OP_SHL, `OP_ROR, `OP_ROL, `OP_NEG, `OP_NOT};
        for (int r = 0; r < `CPU_NREGS; r++) begin
            imem[r] = ldiInstr(regIdx_t'(r), 19'($random(seed)));
        end
        // Operands that build 0x8000FA92 and shift it right by 10.
        imem[1]  = ldiInstr(4'd1, 19'd1);
        imem[2]  = ldiInstr(4'd2, 19'd31);
        imem[3]  = ldiInstr(4'd3, 19'h0FA92);
        imem[4]  = ldiInstr(4'd4, 19'd10);
        imem[16] = aluInstr(`OP_SHL, 4'd5, 4'd1, 4'd2);   // 0x80000000.
        imem[17] = aluInstr(`OP_OR, 4'd6, 4'd5, 4'd3);
        imem[18] = aluInstr(`OP_SHRA, 4'd7, 4'd6, 4'd4);
        imem[19] = aluInstr(5'd1, 4'd8, 4'd0, 4'd0);      // Unknown opcode.
        for (int i = 0; i < 11; i++) begin
            imem[20 + i] = aluInstr(aluOps[i], randReg(), randReg(), randReg());
        end
        for (int i = 31; i < progLen; i++) begin
            imem[i] = aluInstr(mix[{$random(seed)} % 14], randReg(), randReg(), randReg());
        end
    endtask

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        assert (expected == actual) else begin
            valueErrors++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic dropExpected();
        void'(expReg.pop_front());
        void'(expData.pop_front());
        void'(expDue.pop_front());
        void'(expAddr.pop_front());
    endtask

    // Applies a fetched word to the register copy and queues its retire.
    task automatic applyReference(input word_t w, input int addr, input int rspCycle);
        opcode_t op;
        regIdx_t ra;
        word_t   val;
        int      latency;
        op = w[`CPU_OP_HI:`CPU_OP_LO];
        ra = w[`CPU_RA_HI:`CPU_RA_LO];
        latency = 0;
        if (op == `OP_LDI) begin
            val = {{(`CPU_WORD_W - 19){w[`CPU_IMM_HI]}}, w[`CPU_IMM_HI:`CPU_IMM_LO]};
            latency = 2;
        end else if (isAluOpcode(op)) begin
            val = computeExpected(op, refRegs[w[`CPU_RB_HI:`CPU_RB_LO]],
                                  refRegs[w[`CPU_RC_HI:`CPU_RC_LO]]);
            latency = 4;
        end
        if (latency > 0) begin
            refRegs[ra] = val;
            expReg.push_back(ra);
            expData.push_back(val);
            expDue.push_back(rspCycle + latency);
            expAddr.push_back(addr);
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (!rst) begin
            if (memRspValid) begin
                applyReference(rspWord, rspAddr, cycle);
                rspPending = 1'b0;
                rspCount++;
            end
            if (holding) begin
                assert (memReqValid) else begin
                    protocolErrors++;
                    $display("Fetch request was withdrawn before memReqReady at cycle %0d.", cycle);
                end
                checkValue("held fetch address", heldAddr, memReqAddr);
            end
            holding = memReqValid && !memReqReady;
            heldAddr = memReqAddr;
            if (memReqValid && memReqReady) begin
                checkValue("fetch address", word_t'(fetchAddr), memReqAddr);
                fetchAddr++;
                rspAddr = int'(memReqAddr);
                rspWord = (memReqAddr < progLen) ? imem[memReqAddr] : fetchFill(memReqAddr);
                rspPending = 1'b1;
                rspCountdown = 1 + int'({$random(seed)} % 3);
            end
            if (retire.valid) begin
                assert (expReg.size() > 0) else begin
                    protocolErrors++;
                    $display("A register write retired at cycle %0d with none expected.", cycle);
                end
                if (expReg.size() > 0) begin
                    checkValue("retire register", word_t'(expReg[0]), word_t'(retire.regAddr));
                    checkValue("retire data", expData[0], retire.data);
                    if (expAddr[0] == shraAddr) begin
                        checkValue("shra 0x8000FA92 by 10", shraExpect, retire.data);
                    end
                    assert (cycle == expDue[0]) else begin
                        valueErrors++;
                        $display("error retire cycle expected %0d actual %0d", expDue[0], cycle);
                    end
                    dropExpected();
                end
            end else if (expDue.size() > 0) begin
                assert (expDue[0] > cycle) else begin
                    protocolErrors++;
                    $display("No retire came for the instruction at address %0d.", expAddr[0]);
                    dropExpected();
                end
            end
        end
        #1;
        memReqReady = (({$random(seed)} % 4) != 0) && !rst;
        memRspValid = 1'b0;
        if (rspPending) begin
            rspCountdown--;
            if (rspCountdown == 0) begin
                memRspValid = 1'b1;
                memRspData = rspWord;
            end
        end
    end

    initial begin
        rst = 1'b1;
        memReqReady = 1'b0;
        memRspValid = 1'b0;
        memRspData = '0;
        for (int r = 0; r < `CPU_NREGS; r++) begin
            refRegs[r] = '0;
        end
        buildProgram();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        checkValue("reset memReqValid", '0, word_t'(memReqValid));
        checkValue("reset retire valid", '0, word_t'(retire.valid));
        waitCount = 0;
        while ((rspCount < progLen || expReg.size() > 0) && waitCount < waitLimit) begin
            @(posedge clk);
            waitCount++;
        end
        if (rspCount < progLen || expReg.size() > 0) begin
            timeoutErrors++;
            $display("Timed out waiting for the program to fetch and retire.");
        end
        repeat (20) @(negedge clk);  // Filler words must not retire.
        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 valueErrors, protocolErrors, timeoutErrors);
        if (valueErrors + protocolErrors + timeoutErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/cpuPkg.sv
logic/registerFile.sv
logic/alu.sv
control/controlUnit.sv
datapath/datapathCore.sv
logic/cpuTop.sv
tb/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module cpuTb -o cpuTbSim

output=$(./obj_dir/cpuTbSim)
echo "$output"

if grep -qx "Finished with no errors" <<< "$output"; then
    exit 0
fi
exit 1
